// File: design/lsq_pkg.sv
/* widths, queue sizes, index types
   and the load dependence code */
`default_nettype none

package lsq_pkg;

	localparam int DATA_W    = 64;	// data and address
	localparam int PRF_TAG_W = 6;
	localparam int ROB_IDX_W = 5;
	localparam int LQ_SIZE   = 8;	// load slots
	localparam int SQ_SIZE   = 8;	// store entries
	localparam int LQ_IDX_W  = $clog2(LQ_SIZE);
	localparam int SQ_IDX_W  = $clog2(SQ_SIZE);
	localparam int SQ_PTR_W  = SQ_IDX_W + 1;	// extra wrap bit for age compare
	localparam int MEM_TAG_W = 3;
	localparam int MEM_TAGS  = 1 << MEM_TAG_W;	// reads in flight at most

	typedef logic [DATA_W-1:0]    data_t;
	typedef logic [PRF_TAG_W-1:0] prf_tag_t;
	typedef logic [ROB_IDX_W-1:0] rob_idx_t;
	typedef logic [LQ_IDX_W-1:0]  lq_idx_t;
	typedef logic [SQ_IDX_W-1:0]  sq_idx_t;
	typedef logic [SQ_PTR_W-1:0]  sq_ptr_t;
	typedef logic [MEM_TAG_W-1:0] mem_tag_t;

	// what a pending load does next
	typedef enum logic [1:0] {
		FWD_WAIT   = 2'd0,	// older stores not resolved yet
		FWD_STORE  = 2'd1,	// youngest older match supplies data
		FWD_MEMORY = 2'd2	// no older match, read memory
	} fwd_code_t;

endpackage

`default_nettype wire

// File: design/priority_pick.sv
/* first-set request picker, one-hot grant plus index */
`default_nettype none
`timescale 1ns/1ns

module priority_pick #(
	parameter int width = 8
) (
	input  wire  [width-1:0]         request,
	output logic [width-1:0]         grant,	// one-hot
	output logic                     grant_valid,
	output logic [$clog2(width)-1:0] grant_index
);

	always_comb begin
		grant       = '0;
		grant_valid = 1'b0;
		grant_index = '0;
		for (int i = 0; i < width; i++) begin
			if (request[i] && !grant_valid) begin	// lowest bit wins
				grant[i]    = 1'b1;
				grant_valid = 1'b1;
				grant_index = ($clog2(width))'(i);
			end
		end
	end

endmodule

`default_nettype wire

// File: design/store_queue.sv
/* in-order store buffer: CDB operand capture, commit marking,
   head write to memory and mispredict tail recovery */
`default_nettype none
`timescale 1ns/1ns

module store_queue (
	input  wire                          clock,
	input  wire                          reset,
	input  wire                          dispatch_store,
	input  wire  lsq_pkg::data_t         base_value,
	input  wire  lsq_pkg::data_t         offset_value,	// tag in low bits if not valid
	input  wire                          offset_valid,
	input  wire  lsq_pkg::data_t         store_data,
	input  wire                          store_data_valid,
	input  wire  lsq_pkg::rob_idx_t      rob_idx,
	input  wire                          cdb_valid,
	input  wire  lsq_pkg::prf_tag_t      cdb_tag,
	input  wire  lsq_pkg::data_t         cdb_data,
	input  wire                          rob_commit_valid,
	input  wire  lsq_pkg::rob_idx_t      rob_commit_idx,
	input  wire                          mispredict,
	output logic                         sq_full,
	output lsq_pkg::sq_ptr_t             sq_head,
	output lsq_pkg::sq_ptr_t             sq_tail,
	output logic [lsq_pkg::SQ_SIZE-1:0]  entry_valid,
	output lsq_pkg::data_t               entry_addr [lsq_pkg::SQ_SIZE],
	output logic [lsq_pkg::SQ_SIZE-1:0]  entry_addr_ready,
	output lsq_pkg::data_t               entry_data [lsq_pkg::SQ_SIZE],
	output logic [lsq_pkg::SQ_SIZE-1:0]  entry_data_ready,
	output logic                         mem_store_valid,
	output lsq_pkg::data_t               mem_store_addr,
	output lsq_pkg::data_t               mem_store_data
);

	lsq_pkg::prf_tag_t offset_tag [lsq_pkg::SQ_SIZE];	// waiting offset operand
	lsq_pkg::prf_tag_t data_tag [lsq_pkg::SQ_SIZE];	// waiting store data
	lsq_pkg::rob_idx_t entry_rob [lsq_pkg::SQ_SIZE];
	logic [lsq_pkg::SQ_SIZE-1:0] committed;
	logic [lsq_pkg::SQ_SIZE-1:0] commit_hit;	// commit strobe matches this entry
	lsq_pkg::sq_idx_t head_idx;
	lsq_pkg::sq_idx_t tail_idx;
	lsq_pkg::sq_ptr_t keep_tail;	// tail after a flush
	lsq_pkg::data_t   offset_term;
	logic             offset_hit;
	logic             data_hit;

	assign head_idx = lsq_pkg::sq_idx_t'(sq_head);
	assign tail_idx = lsq_pkg::sq_idx_t'(sq_tail);
	assign sq_full  = (head_idx == tail_idx)	// same slot, different lap
		&& (sq_head[lsq_pkg::SQ_IDX_W] != sq_tail[lsq_pkg::SQ_IDX_W]);

	// operand broadcast in the dispatch cycle itself
	assign offset_hit  = !offset_valid && cdb_valid
		&& cdb_tag == lsq_pkg::prf_tag_t'(offset_value);
	assign data_hit    = !store_data_valid && cdb_valid
		&& cdb_tag == lsq_pkg::prf_tag_t'(store_data);
	assign offset_term = offset_valid ? offset_value : (offset_hit ? cdb_data : '0);

	// head write, driven straight from the entry flops
	assign mem_store_valid = entry_valid[head_idx] && committed[head_idx]
		&& entry_data_ready[head_idx];
	assign mem_store_addr  = entry_addr[head_idx];
	assign mem_store_data  = entry_data[head_idx];

	always_comb begin
		lsq_pkg::sq_ptr_t ptr;
		keep_tail = sq_head;
		for (int i = 0; i < lsq_pkg::SQ_SIZE; i++) begin
			commit_hit[i] = rob_commit_valid && entry_valid[i] && entry_rob[i] == rob_commit_idx;
		end
		for (int i = 0; i < lsq_pkg::SQ_SIZE; i++) begin	// youngest committed survives
			ptr = sq_head + lsq_pkg::sq_ptr_t'(i);
			if (entry_valid[lsq_pkg::sq_idx_t'(ptr)]
					&& (committed[lsq_pkg::sq_idx_t'(ptr)] || commit_hit[lsq_pkg::sq_idx_t'(ptr)]))
				keep_tail = ptr + 1'b1;
		end
	end

	//////////////////////////////
	// entry state
	always_ff @(posedge clock) begin
		if (reset) begin
			sq_head          <= '0;
			sq_tail          <= '0;
			entry_valid      <= '0;
			entry_addr_ready <= '0;
			entry_data_ready <= '0;
			committed        <= '0;
		end else begin
			for (int i = 0; i < lsq_pkg::SQ_SIZE; i++) begin
				if (cdb_valid && entry_valid[i] && !entry_addr_ready[i] && cdb_tag == offset_tag[i]) begin
					entry_addr[i]       <= entry_addr[i] + cdb_data;	// base held until now
					entry_addr_ready[i] <= 1'b1;
				end
				if (cdb_valid && entry_valid[i] && !entry_data_ready[i] && cdb_tag == data_tag[i]) begin
					entry_data[i]       <= cdb_data;
					entry_data_ready[i] <= 1'b1;
				end
				if (commit_hit[i])
					committed[i] <= 1'b1;
			end
			if (mem_store_valid) begin	// head retires to memory
				entry_valid[head_idx] <= 1'b0;
				committed[head_idx]   <= 1'b0;
				sq_head               <= sq_head + 1'b1;
			end
			if (mispredict) begin
				for (int i = 0; i < lsq_pkg::SQ_SIZE; i++) begin
					if (!committed[i] && !commit_hit[i])
						entry_valid[i] <= 1'b0;	// speculative store dropped
				end
				sq_tail <= keep_tail;
			end else if (dispatch_store) begin
				entry_valid[tail_idx]      <= 1'b1;
				committed[tail_idx]        <= 1'b0;
				entry_rob[tail_idx]        <= rob_idx;
				entry_addr[tail_idx]       <= base_value + offset_term;
				entry_addr_ready[tail_idx] <= offset_valid || offset_hit;
				offset_tag[tail_idx]       <= lsq_pkg::prf_tag_t'(offset_value);
				entry_data[tail_idx]       <= data_hit ? cdb_data : store_data;
				entry_data_ready[tail_idx] <= store_data_valid || data_hit;
				data_tag[tail_idx]         <= lsq_pkg::prf_tag_t'(store_data);
				sq_tail                    <= sq_tail + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// File: design/store_forward.sv
/* older-store search per load slot, yields wait, forward or memory */
`default_nettype none
`timescale 1ns/1ns

module store_forward (
	input  wire  [lsq_pkg::SQ_SIZE-1:0] entry_valid,
	input  wire  lsq_pkg::data_t        entry_addr [lsq_pkg::SQ_SIZE],
	input  wire  [lsq_pkg::SQ_SIZE-1:0] entry_addr_ready,
	input  wire  lsq_pkg::data_t        entry_data [lsq_pkg::SQ_SIZE],
	input  wire  [lsq_pkg::SQ_SIZE-1:0] entry_data_ready,
	input  wire  lsq_pkg::sq_ptr_t      sq_head,
	input  wire  [lsq_pkg::LQ_SIZE-1:0] load_valid,
	input  wire  lsq_pkg::data_t        load_addr [lsq_pkg::LQ_SIZE],
	input  wire  [lsq_pkg::LQ_SIZE-1:0] load_addr_ready,
	input  wire  [lsq_pkg::LQ_SIZE-1:0] load_data_ready,
	input  wire  lsq_pkg::sq_ptr_t      load_boundary [lsq_pkg::LQ_SIZE],
	output lsq_pkg::fwd_code_t          fwd_code [lsq_pkg::LQ_SIZE],
	output lsq_pkg::data_t              fwd_data [lsq_pkg::LQ_SIZE]
);

	always_comb begin
		lsq_pkg::sq_ptr_t ptr;
		lsq_pkg::sq_idx_t idx;
		logic older;	// still before the load's boundary
		logic unknown;	// some older store lacks its address
		logic hit;
		logic hit_ready;
		for (int s = 0; s < lsq_pkg::LQ_SIZE; s++) begin
			older       = 1'b1;
			unknown     = 1'b0;
			hit         = 1'b0;
			hit_ready   = 1'b0;
			fwd_data[s] = '0;
			// walk head to boundary, later matches are younger and overwrite
			for (int i = 0; i < lsq_pkg::SQ_SIZE; i++) begin
				ptr = sq_head + lsq_pkg::sq_ptr_t'(i);
				idx = lsq_pkg::sq_idx_t'(ptr);
				if (ptr == load_boundary[s])
					older = 1'b0;
				if (older && entry_valid[idx]) begin
					if (!entry_addr_ready[idx]) begin
						unknown = 1'b1;
					end else if (entry_addr[idx] == load_addr[s]) begin
						hit         = 1'b1;
						hit_ready   = entry_data_ready[idx];
						fwd_data[s] = entry_data[idx];
					end
				end
			end
			if (!load_valid[s] || !load_addr_ready[s] || load_data_ready[s] || unknown)
				fwd_code[s] = lsq_pkg::FWD_WAIT;
			else if (hit)
				fwd_code[s] = hit_ready ? lsq_pkg::FWD_STORE : lsq_pkg::FWD_WAIT;
			else
				fwd_code[s] = lsq_pkg::FWD_MEMORY;
		end
	end

endmodule

`default_nettype wire

// File: design/load_queue.sv
/* load slots: allocation, address wake-up, data fill
   from forward or memory, and result broadcast */
`default_nettype none
`timescale 1ns/1ns

module load_queue (
	input  wire                          clock,
	input  wire                          reset,
	input  wire                          dispatch_load,
	input  wire  lsq_pkg::data_t         base_value,
	input  wire  lsq_pkg::data_t         offset_value,
	input  wire                          offset_valid,
	input  wire  lsq_pkg::prf_tag_t      dest_tag,
	input  wire  lsq_pkg::sq_ptr_t       sq_tail,
	input  wire                          cdb_valid,
	input  wire  lsq_pkg::prf_tag_t      cdb_tag,
	input  wire  lsq_pkg::data_t         cdb_data,
	input  wire                          mispredict,
	input  var   lsq_pkg::fwd_code_t     fwd_code [lsq_pkg::LQ_SIZE],
	input  wire  lsq_pkg::data_t         fwd_data [lsq_pkg::LQ_SIZE],
	input  wire  [lsq_pkg::LQ_SIZE-1:0]  mem_issued,
	input  wire                          fill_valid,
	input  wire  lsq_pkg::lq_idx_t       fill_slot,
	input  wire  lsq_pkg::data_t         fill_data,
	output logic                         lq_full,
	output logic [lsq_pkg::LQ_SIZE-1:0]  load_valid,
	output lsq_pkg::data_t               load_addr [lsq_pkg::LQ_SIZE],
	output logic [lsq_pkg::LQ_SIZE-1:0]  load_addr_ready,
	output logic [lsq_pkg::LQ_SIZE-1:0]  load_data_ready,
	output lsq_pkg::sq_ptr_t             load_boundary [lsq_pkg::LQ_SIZE],
	output logic [lsq_pkg::LQ_SIZE-1:0]  mem_wanted,
	output logic                         result_valid,
	output lsq_pkg::prf_tag_t            result_tag,
	output lsq_pkg::data_t               result_data
);

	lsq_pkg::prf_tag_t offset_tag [lsq_pkg::LQ_SIZE];
	lsq_pkg::prf_tag_t slot_dest [lsq_pkg::LQ_SIZE];
	lsq_pkg::data_t    slot_data [lsq_pkg::LQ_SIZE];
	logic [lsq_pkg::LQ_SIZE-1:0] issued;	// read already sent
	logic [lsq_pkg::LQ_SIZE-1:0] free_grant;
	logic                        free_any;
	logic [lsq_pkg::LQ_SIZE-1:0] result_grant;
	lsq_pkg::lq_idx_t            result_idx;
	lsq_pkg::data_t              offset_term;
	logic                        offset_hit;

	priority_pick #(.width(lsq_pkg::LQ_SIZE)) free_pick_i (
		.request     (~load_valid),
		.grant       (free_grant),
		.grant_valid (free_any),
		.grant_index ()
	);

	priority_pick #(.width(lsq_pkg::LQ_SIZE)) result_pick_i (
		.request     (load_valid & load_data_ready),
		.grant       (result_grant),
		.grant_valid (result_valid),
		.grant_index (result_idx)
	);

	assign lq_full     = !free_any;
	assign result_tag  = slot_dest[result_idx];
	assign result_data = slot_data[result_idx];
	assign offset_hit  = !offset_valid && cdb_valid
		&& cdb_tag == lsq_pkg::prf_tag_t'(offset_value);
	assign offset_term = offset_valid ? offset_value : (offset_hit ? cdb_data : '0);

	always_comb begin
		for (int s = 0; s < lsq_pkg::LQ_SIZE; s++)
			mem_wanted[s] = !issued[s] && fwd_code[s] == lsq_pkg::FWD_MEMORY;	// held until issued
	end

	//////////////////////////////
	// slot state
	always_ff @(posedge clock) begin
		if (reset || mispredict) begin	// a flush empties every slot
			load_valid      <= '0;
			load_addr_ready <= '0;
			load_data_ready <= '0;
			issued          <= '0;
		end else begin
			for (int s = 0; s < lsq_pkg::LQ_SIZE; s++) begin
				if (cdb_valid && load_valid[s] && !load_addr_ready[s] && cdb_tag == offset_tag[s]) begin
					load_addr[s]       <= load_addr[s] + cdb_data;
					load_addr_ready[s] <= 1'b1;
				end
				if (fwd_code[s] == lsq_pkg::FWD_STORE) begin	// store forward
					slot_data[s]       <= fwd_data[s];
					load_data_ready[s] <= 1'b1;
				end
				if (fill_valid && fill_slot == lsq_pkg::lq_idx_t'(s) && load_valid[s]) begin
					slot_data[s]       <= fill_data;
					load_data_ready[s] <= 1'b1;
				end
				if (mem_issued[s])
					issued[s] <= 1'b1;
				if (result_grant[s]) begin	// broadcast frees the slot
					load_valid[s]      <= 1'b0;
					load_data_ready[s] <= 1'b0;
				end
				if (dispatch_load && free_grant[s]) begin
					load_valid[s]      <= 1'b1;
					load_addr[s]       <= base_value + offset_term;
					load_addr_ready[s] <= offset_valid || offset_hit;
					offset_tag[s]      <= lsq_pkg::prf_tag_t'(offset_value);
					slot_dest[s]       <= dest_tag;
					load_boundary[s]   <= sq_tail;	// stores before this are older
					load_data_ready[s] <= 1'b0;
					issued[s]          <= 1'b0;
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: design/mem_load_port.sv
/* memory read issue, tag allocation and response routing */
`default_nettype none
`timescale 1ns/1ns

module mem_load_port (
	input  wire                          clock,
	input  wire                          reset,
	input  wire  [lsq_pkg::LQ_SIZE-1:0]  mem_wanted,
	input  wire  lsq_pkg::data_t         load_addr [lsq_pkg::LQ_SIZE],
	input  wire                          mispredict,
	input  wire                          mem_resp_valid,
	input  wire  lsq_pkg::mem_tag_t      mem_resp_tag,
	input  wire  lsq_pkg::data_t         mem_resp_data,
	output logic [lsq_pkg::LQ_SIZE-1:0]  mem_issued,
	output logic                         mem_req_valid,
	output lsq_pkg::data_t               mem_req_addr,
	output lsq_pkg::mem_tag_t            mem_req_tag,
	output logic                         fill_valid,
	output lsq_pkg::lq_idx_t             fill_slot,
	output lsq_pkg::data_t               fill_data
);

	logic [lsq_pkg::MEM_TAGS-1:0] tag_busy;	// read outstanding
	logic [lsq_pkg::MEM_TAGS-1:0] tag_stale;	// owner flushed, drop response
	lsq_pkg::lq_idx_t             tag_slot [lsq_pkg::MEM_TAGS];
	lsq_pkg::mem_tag_t            next_tag;
	logic [lsq_pkg::LQ_SIZE-1:0]  pick_grant;
	logic                         pick_valid;
	lsq_pkg::lq_idx_t             pick_idx;

	priority_pick #(.width(lsq_pkg::LQ_SIZE)) read_pick_i (
		.request     (mem_wanted),
		.grant       (pick_grant),
		.grant_valid (pick_valid),
		.grant_index (pick_idx)
	);

	assign mem_req_valid = pick_valid && !tag_busy[next_tag] && !mispredict;	// stall on reuse
	assign mem_req_addr  = load_addr[pick_idx];
	assign mem_req_tag   = next_tag;
	assign mem_issued    = mem_req_valid ? pick_grant : '0;
	assign fill_valid    = mem_resp_valid && tag_busy[mem_resp_tag] && !tag_stale[mem_resp_tag];
	assign fill_slot     = tag_slot[mem_resp_tag];
	assign fill_data     = mem_resp_data;

	always_ff @(posedge clock) begin
		if (reset) begin
			tag_busy  <= '0;
			tag_stale <= '0;
			next_tag  <= '0;
		end else begin
			if (mispredict)
				tag_stale <= tag_stale | tag_busy;	// whole table invalid
			if (mem_resp_valid) begin
				tag_busy[mem_resp_tag]  <= 1'b0;
				tag_stale[mem_resp_tag] <= 1'b0;
			end
			if (mem_req_valid) begin
				tag_busy[next_tag]  <= 1'b1;
				tag_stale[next_tag] <= 1'b0;
				tag_slot[next_tag]  <= pick_idx;
				next_tag            <= next_tag + 1'b1;	// wraps
			end
		end
	end

endmodule

`default_nettype wire

// File: design/lsq.sv
/* load/store queue top, store queue, forward search,
   load queue and memory read port */
`default_nettype none
`timescale 1ns/1ns

module lsq (
	input  wire                     clock,
	input  wire                     reset,
	input  wire                     dispatch_load,
	input  wire                     dispatch_store,
	input  wire  lsq_pkg::data_t    base_value,
	input  wire  lsq_pkg::data_t    offset_value,
	input  wire                     offset_valid,
	input  wire  lsq_pkg::data_t    store_data,
	input  wire                     store_data_valid,
	input  wire  lsq_pkg::prf_tag_t dest_tag,
	input  wire  lsq_pkg::rob_idx_t rob_idx,
	output logic                    lq_full,
	output logic                    sq_full,
	input  wire                     cdb_valid,
	input  wire  lsq_pkg::prf_tag_t cdb_tag,
	input  wire  lsq_pkg::data_t    cdb_data,
	input  wire                     rob_commit_valid,
	input  wire  lsq_pkg::rob_idx_t rob_commit_idx,
	input  wire                     mispredict,
	output logic                    mem_req_valid,
	output lsq_pkg::data_t          mem_req_addr,
	output lsq_pkg::mem_tag_t       mem_req_tag,
	input  wire                     mem_resp_valid,
	input  wire  lsq_pkg::mem_tag_t mem_resp_tag,
	input  wire  lsq_pkg::data_t    mem_resp_data,
	output logic                    mem_store_valid,
	output lsq_pkg::data_t          mem_store_addr,
	output lsq_pkg::data_t          mem_store_data,
	output logic                    result_valid,
	output lsq_pkg::prf_tag_t       result_tag,
	output lsq_pkg::data_t          result_data
);

	// store queue view for the forward search
	lsq_pkg::sq_ptr_t            sq_head;
	lsq_pkg::sq_ptr_t            sq_tail;
	logic [lsq_pkg::SQ_SIZE-1:0] entry_valid;
	lsq_pkg::data_t              entry_addr [lsq_pkg::SQ_SIZE];
	logic [lsq_pkg::SQ_SIZE-1:0] entry_addr_ready;
	lsq_pkg::data_t              entry_data [lsq_pkg::SQ_SIZE];
	logic [lsq_pkg::SQ_SIZE-1:0] entry_data_ready;

	// load slot view and decisions
	logic [lsq_pkg::LQ_SIZE-1:0] load_valid;
	lsq_pkg::data_t              load_addr [lsq_pkg::LQ_SIZE];
	logic [lsq_pkg::LQ_SIZE-1:0] load_addr_ready;
	logic [lsq_pkg::LQ_SIZE-1:0] load_data_ready;
	lsq_pkg::sq_ptr_t            load_boundary [lsq_pkg::LQ_SIZE];
	lsq_pkg::fwd_code_t          fwd_code [lsq_pkg::LQ_SIZE];
	lsq_pkg::data_t              fwd_data [lsq_pkg::LQ_SIZE];

	// memory read path
	logic [lsq_pkg::LQ_SIZE-1:0] mem_wanted;
	logic [lsq_pkg::LQ_SIZE-1:0] mem_issued;
	logic                        fill_valid;
	lsq_pkg::lq_idx_t            fill_slot;
	lsq_pkg::data_t              fill_data;

	store_queue store_queue_i (.*);	// names match one to one

	store_forward store_forward_i (.*);

	load_queue load_queue_i (.*);

	mem_load_port mem_load_port_i (.*);

endmodule

`default_nettype wire

// File: testbench/lsq_tb.sv
/* load/store queue testbench: clock, memory model with xorshift delay,
   directed tests with immediate-assertion checks and a cycle limit */
`default_nettype none
`timescale 1ns/1ns

module lsq_tb;

	localparam int CYCLE_LIMIT = 2000;	// six tests run a few hundred cycles
	localparam int LOG_READ    = 0;
	localparam int LOG_STORE   = 1;
	localparam int LOG_RESULT  = 2;

	logic clock;
	logic reset;
	logic dispatch_load;
	logic dispatch_store;
	lsq_pkg::data_t base_value;
	lsq_pkg::data_t offset_value;
	logic offset_valid;
	lsq_pkg::data_t store_data;
	logic store_data_valid;
	lsq_pkg::prf_tag_t dest_tag;
	lsq_pkg::rob_idx_t rob_idx;
	logic lq_full;
	logic sq_full;
	logic cdb_valid;
	lsq_pkg::prf_tag_t cdb_tag;
	lsq_pkg::data_t cdb_data;
	logic rob_commit_valid;
	lsq_pkg::rob_idx_t rob_commit_idx;
	logic mispredict;
	logic mem_req_valid;
	lsq_pkg::data_t mem_req_addr;
	lsq_pkg::mem_tag_t mem_req_tag;
	logic mem_resp_valid;
	lsq_pkg::mem_tag_t mem_resp_tag;
	lsq_pkg::data_t mem_resp_data;
	logic mem_store_valid;
	lsq_pkg::data_t mem_store_addr;
	lsq_pkg::data_t mem_store_data;
	logic result_valid;
	lsq_pkg::prf_tag_t result_tag;
	lsq_pkg::data_t result_data;

	lsq_pkg::data_t    req_addr [$];	// every read seen on the bus
	lsq_pkg::data_t    st_addr [$];
	lsq_pkg::data_t    st_data [$];
	lsq_pkg::prf_tag_t res_tag [$];
	lsq_pkg::data_t    res_data [$];
	lsq_pkg::mem_tag_t pend_tag [$];	// model reads not yet answered
	lsq_pkg::data_t    pend_addr [$];
	int                pend_due [$];
	logic [31:0] rng;
	logic hold;	// memory busy, answers nothing
	int cycle = 0;
	int errors = 0;
	int checks = 0;
	int tests = 0;
	int start_errors;

	lsq dut_i (.*);

	initial begin
		clock = 1'b0;
		forever #4 clock = ~clock;
	end

	always @(posedge clock) begin
		cycle = cycle + 1;
		if (cycle >= CYCLE_LIMIT) begin
			$display("timeout: tests still running after %0d cycles", cycle);
			$display("ERRORS FOUND");
			$finish;
		end
	end

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// memory contents, every address bit matters
	function automatic lsq_pkg::data_t mem_word(input lsq_pkg::data_t addr);
		return {addr[31:0] ^ 32'ha5a5_0f0f, addr[63:32] ^ addr[31:0] ^ 32'h1234_8765};
	endfunction

	function automatic int log_size(input int kind);
		case (kind)
			LOG_READ:  return req_addr.size();
			LOG_STORE: return st_addr.size();
			default:   return res_tag.size();
		endcase
	endfunction

	//////////////////////////////
	// bus monitor and memory model
	always @(negedge clock) begin
		if (!reset) begin
			if (mem_req_valid) begin	// answer 1 to 6 cycles later
				foreach (pend_tag[i]) begin	// tag must not be in flight
					checks++;
					assert (mem_req_tag != pend_tag[i]) else begin
						$display("ERROR at %0t ns: mem_req_tag is %0d, expected any tag but %0d",
							$time, mem_req_tag, pend_tag[i]);
						errors++;
					end
				end
				rng = xorshift(rng);
				req_addr.push_back(mem_req_addr);
				pend_tag.push_back(mem_req_tag);
				pend_addr.push_back(mem_req_addr);
				pend_due.push_back(cycle + 1 + int'(rng % 6));
			end
			if (mem_store_valid) begin
				st_addr.push_back(mem_store_addr);
				st_data.push_back(mem_store_data);
			end
			if (result_valid) begin
				res_tag.push_back(result_tag);
				res_data.push_back(result_data);
			end
		end
	end

	always @(posedge clock) begin
		#1;
		mem_resp_valid = 1'b0;
		if (!hold && pend_tag.size() > 0 && cycle >= pend_due[0]) begin
			mem_resp_valid = 1'b1;
			mem_resp_tag   = pend_tag.pop_front();
			mem_resp_data  = mem_word(pend_addr.pop_front());
			pend_due.delete(0);
		end
	end

	//////////////////////////////
	// drive and check helpers
	task automatic step();
		@(posedge clock);
		#1;	// inputs change just after the edge
	endtask

	task automatic idle(input int n);
		repeat (n) step();
	endtask

	task automatic send_load(input lsq_pkg::data_t base, input lsq_pkg::data_t off,
			input logic off_ok, input lsq_pkg::prf_tag_t dest);
		base_value    = base;
		offset_value  = off;	// tag in low bits when not ok
		offset_valid  = off_ok;
		dest_tag      = dest;
		dispatch_load = 1'b1;
		step();
		dispatch_load = 1'b0;
	endtask

	task automatic send_store(input lsq_pkg::data_t base, input lsq_pkg::data_t off,
			input logic off_ok, input lsq_pkg::data_t data, input logic data_ok,
			input lsq_pkg::rob_idx_t rob);
		base_value       = base;
		offset_value     = off;
		offset_valid     = off_ok;
		store_data       = data;
		store_data_valid = data_ok;
		rob_idx          = rob;
		dispatch_store   = 1'b1;
		step();
		dispatch_store   = 1'b0;
	endtask

	task automatic commit(input lsq_pkg::rob_idx_t idx);
		rob_commit_valid = 1'b1;
		rob_commit_idx   = idx;
		step();
		rob_commit_valid = 1'b0;
	endtask

	task automatic broadcast(input lsq_pkg::prf_tag_t tag, input lsq_pkg::data_t data);
		cdb_valid = 1'b1;
		cdb_tag   = tag;
		cdb_data  = data;
		step();
		cdb_valid = 1'b0;
	endtask

	task automatic check_value(input string name, input lsq_pkg::data_t got,
			input lsq_pkg::data_t exp);
		checks++;
		assert (got === exp) else begin
			$display("ERROR at %0t ns: %s is %h, expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic check_count(input string what, input int got, input int exp);
		checks++;
		assert (got == exp) else begin
			$display("%s: counted %0d, expected %0d", what, got, exp);
			errors++;
		end
	endtask

	task automatic wait_count(input int kind, input int n, input int limit, input string what);
		int waited;
		waited = 0;
		while (log_size(kind) < n && waited < limit) begin
			step();
			waited++;
		end
		checks++;
		assert (log_size(kind) >= n) else begin
			$display("%s: only %0d of %0d seen within %0d cycles", what, log_size(kind), n, limit);
			errors++;
		end
	endtask

	task automatic check_result(input lsq_pkg::prf_tag_t tag, input lsq_pkg::data_t exp);
		int hit;
		hit = -1;
		foreach (res_tag[i])
			if (res_tag[i] == tag)
				hit = i;
		checks++;
		assert (hit >= 0) else begin
			$display("no result broadcast for load tag %0d", tag);
			errors++;
		end
		if (hit >= 0)
			check_value("result_data", res_data[hit], exp);
	endtask

	task automatic no_read_at(input lsq_pkg::data_t addr);
		int seen;
		seen = 0;
		foreach (req_addr[i])
			if (req_addr[i] == addr)
				seen++;
		check_count($sformatf("memory reads at forwarded address %h", addr), seen, 0);
	endtask

	task automatic begin_test();
		start_errors = errors;
		req_addr.delete();
		st_addr.delete();
		st_data.delete();
		res_tag.delete();
		res_data.delete();
	endtask

	task automatic end_test(input string name);
		tests++;
		$display("%s: finished with %0d errors", name, errors - start_errors);
	endtask

	//////////////////////////////
	// directed tests
	task automatic test_reset_and_load();
		begin_test();
		check_value("lq_full", lq_full, 0);
		check_value("sq_full", sq_full, 0);
		check_value("result_valid", result_valid, 0);
		check_value("mem_req_valid", mem_req_valid, 0);
		check_value("mem_store_valid", mem_store_valid, 0);
		send_load(64'h1000, 64'h20, 1'b1, 6'd5);
		wait_count(LOG_RESULT, 1, 30, "load results");
		check_count("memory reads", req_addr.size(), 1);
		check_value("mem_req_addr", req_addr[0], 64'h1020);
		check_result(6'd5, mem_word(64'h1020));
		end_test("reset and plain load");
	endtask

	task automatic test_forwarding();
		begin_test();
		send_store(64'h1f00, 64'h100, 1'b1, 64'hdead_beef_0000_0001, 1'b1, 5'd1);
		send_load(64'h2000, 64'h0, 1'b1, 6'd7);
		wait_count(LOG_RESULT, 1, 30, "load results");
		check_result(6'd7, 64'hdead_beef_0000_0001);
		send_store(64'h2000, 64'h0, 1'b1, 64'hdead_beef_0000_0002, 1'b1, 5'd2);
		send_store(64'h2000, 64'h0, 1'b1, 64'hdead_beef_0000_0003, 1'b1, 5'd3);
		send_load(64'h1ff8, 64'h8, 1'b1, 6'd8);	// same address, younger store wins
		wait_count(LOG_RESULT, 2, 30, "load results");
		check_result(6'd8, 64'hdead_beef_0000_0003);
		no_read_at(64'h2000);
		commit(5'd1);
		commit(5'd2);
		commit(5'd3);
		wait_count(LOG_STORE, 3, 30, "store writes");
		end_test("store to load forwarding");
	endtask

	task automatic test_no_match();
		begin_test();
		send_store(64'h3000, 64'h0, 1'b1, 64'h0bad_0bad_3000_3000, 1'b1, 5'd4);
		send_load(64'h3100, 64'h0, 1'b1, 6'd9);
		wait_count(LOG_RESULT, 1, 30, "load results");
		check_count("memory reads", req_addr.size(), 1);
		check_value("mem_req_addr", req_addr[0], 64'h3100);
		check_result(6'd9, mem_word(64'h3100));
		commit(5'd4);
		wait_count(LOG_STORE, 1, 20, "store writes");
		end_test("non-matching store");
	endtask

	task automatic test_cdb_wakeup();
		begin_test();
		send_store(64'h3f00, 64'd40, 1'b0, 64'd41, 1'b0, 5'd5);	// offset and data as tags
		send_load(64'h3ff0, 64'd42, 1'b0, 6'd20);
		send_load(64'h4800, 64'h0, 1'b1, 6'd21);
		idle(6);
		check_count("reads while store address unknown", req_addr.size(), 0);
		broadcast(6'd42, 64'h10);	// load now at 4000
		idle(3);
		check_count("reads while store address unknown", req_addr.size(), 0);
		broadcast(6'd40, 64'h100);	// store now at 4000
		broadcast(6'd41, 64'hcafe_0000_4000_0041);
		wait_count(LOG_RESULT, 2, 40, "load results");
		check_result(6'd20, 64'hcafe_0000_4000_0041);
		check_result(6'd21, mem_word(64'h4800));
		check_count("memory reads", req_addr.size(), 1);
		no_read_at(64'h4000);
		commit(5'd5);
		wait_count(LOG_STORE, 1, 20, "store writes");
		check_value("mem_store_addr", st_addr[0], 64'h4000);
		check_value("mem_store_data", st_data[0], 64'hcafe_0000_4000_0041);
		end_test("cdb wake-up");
	endtask

	task automatic test_store_commit();
		begin_test();
		send_store(64'h5000, 64'h0, 1'b1, 64'h5000_0000_0000_0050, 1'b1, 5'd6);
		send_store(64'h5008, 64'h0, 1'b1, 64'd43, 1'b0, 5'd7);	// data pending
		send_store(64'h5010, 64'h0, 1'b1, 64'h5000_0000_0000_0052, 1'b1, 5'd8);
		commit(5'd8);	// reverse order
		commit(5'd7);
		commit(5'd6);
		wait_count(LOG_STORE, 1, 20, "store writes");
		idle(6);
		check_count("store writes before cdb data", st_addr.size(), 1);
		broadcast(6'd43, 64'h5000_0000_0000_0051);
		wait_count(LOG_STORE, 3, 20, "store writes");
		check_value("mem_store_addr", st_addr[0], 64'h5000);
		check_value("mem_store_data", st_data[0], 64'h5000_0000_0000_0050);
		check_value("mem_store_addr", st_addr[1], 64'h5008);
		check_value("mem_store_data", st_data[1], 64'h5000_0000_0000_0051);
		check_value("mem_store_addr", st_addr[2], 64'h5010);
		check_value("mem_store_data", st_data[2], 64'h5000_0000_0000_0052);
		end_test("store commit order");
	endtask

	task automatic test_mispredict();
		begin_test();
		hold = 1'b1;	// keep reads outstanding
		send_store(64'h6000, 64'h0, 1'b1, 64'd44, 1'b0, 5'd9);
		commit(5'd9);
		for (int i = 0; i < lsq_pkg::SQ_SIZE - 1; i++)	// speculative stores fill the queue
			send_store(64'h6100 + 64'(8 * i), 64'h0, 1'b1, 64'h6000_0000_0000_0061, 1'b1,
				5'(10 + i));
		for (int i = 0; i < lsq_pkg::LQ_SIZE; i++)	// every slot waits on memory
			send_load(64'h6200 + 64'(8 * i), 64'h0, 1'b1, 6'(30 + i));
		wait_count(LOG_READ, lsq_pkg::LQ_SIZE, 20, "memory reads");
		check_value("lq_full", lq_full, 1);
		check_value("sq_full", sq_full, 1);
		mispredict = 1'b1;
		step();
		mispredict = 1'b0;
		check_value("lq_full", lq_full, 0);
		check_value("sq_full", sq_full, 0);
		hold = 1'b0;	// late answers for flushed loads
		idle(12);
		check_count("results from flushed loads", res_tag.size(), 0);
		broadcast(6'd44, 64'h6000_0000_0000_0060);
		wait_count(LOG_STORE, 1, 20, "store writes");
		idle(4);
		check_count("store writes after flush", st_addr.size(), 1);
		check_value("mem_store_addr", st_addr[0], 64'h6000);
		check_value("mem_store_data", st_data[0], 64'h6000_0000_0000_0060);
		send_load(64'h6400, 64'h0, 1'b1, 6'd40);
		wait_count(LOG_RESULT, 1, 30, "load results");
		check_result(6'd40, mem_word(64'h6400));
		end_test("mispredict flush");
	endtask

	initial begin
		reset            = 1'b1;
		dispatch_load    = 1'b0;
		dispatch_store   = 1'b0;
		base_value       = '0;
		offset_value     = '0;
		offset_valid     = 1'b0;
		store_data       = '0;
		store_data_valid = 1'b0;
		dest_tag         = '0;
		rob_idx          = '0;
		cdb_valid        = 1'b0;
		cdb_tag          = '0;
		cdb_data         = '0;
		rob_commit_valid = 1'b0;
		rob_commit_idx   = '0;
		mispredict       = 1'b0;
		mem_resp_valid   = 1'b0;
		mem_resp_tag     = '0;
		mem_resp_data    = '0;
		hold             = 1'b0;
		rng              = 32'h9325_eaa5;
		repeat (10) @(posedge clock);
		#1 reset = 1'b0;
		test_reset_and_load();
		test_forwarding();
		test_no_match();
		test_cdb_wakeup();
		test_store_commit();
		test_mispredict();
		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

`default_nettype wire

// File: lsq.f
design/lsq_pkg.sv
design/priority_pick.sv
design/store_queue.sv
design/store_forward.sv
design/load_queue.sv
design/mem_load_port.sv
design/lsq.sv
testbench/lsq_tb.sv

// File: Bender.yml
package:
  name: lsq

sources:
  - files:
      - design/lsq_pkg.sv
      - design/priority_pick.sv
      - design/store_queue.sv
      - design/store_forward.sv
      - design/load_queue.sv
      - design/mem_load_port.sv
      - design/lsq.sv
  - target: test
    files:
      - testbench/lsq_tb.sv
